/* include/board_config.svh */
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Board clock in MHz
`define CLK_MHZ          25

// Clock cycles per half period of the I2S bit clocks
`define MIC_HALF_PERIOD  2   // 64 sck per frame -> 256 clk
`define OUT_HALF_PERIOD  5   // 32 bclk per frame -> 320 clk

`endif

/* verilog/audio_pkg.sv */
package audio_pkg;

    localparam w_mic_bits   = 24,
               w_sound_bits = 16;

    //------------------------------
    // Sample words

    typedef logic signed [w_mic_bits   - 1:0] mic_sample_t;  // MSB first on the wire
    typedef logic signed [w_sound_bits - 1:0] sound_t;

    //------------------------------
    // Pin groups

    typedef struct packed
    {
        logic sck;
        logic ws;   // Low selects left slot
        logic lr;   // Held low, microphone answers in left slot
    } mic_pins_t;

    typedef struct packed
    {
        logic mclk;
        logic bclk;
        logic lrclk;  // Low is left channel
        logic sdata;
    } i2s_out_pins_t;

    // Sticky until reset
    typedef struct packed
    {
        logic overflow;
        logic underrun;
    } audio_flags_t;

endpackage

/* verilog/inmp441_mic_i2s_receiver.sv */
`timescale 1ns/100ps

module inmp441_mic_i2s_receiver
# (
    parameter mic_half_period = 2
)
(
    input                          clk,
    input                          rst,
    input                          sd,
    output audio_pkg::mic_pins_t   mic,
    output audio_pkg::mic_sample_t sample,
    output logic                   sample_valid
);

    import audio_pkg::*;

    localparam w_div = $clog2 (mic_half_period + 1);

    logic [w_div - 1:0] div_cnt;
    logic               sck;
    logic [        5:0] bit_cnt;   // sck cycle within the 64-cycle frame
    mic_sample_t        shift;

    //------------------------------
    // sck and ws generation

    wire toggle   = (div_cnt == w_div' (mic_half_period - 1));
    wire sck_rise = toggle & ~ sck;
    wire sck_fall = toggle &   sck;

    // One-bit delay after ws falls, then 24 data bits
    wire in_slot  = (bit_cnt >= 6'd1) && (bit_cnt <= 6'd24);

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            div_cnt      <= '0;
            sck          <= 1'b0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            if (toggle)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (toggle)
                sck <= ~ sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;   // Wraps at 64, ws follows bit 5

            // Last data bit goes in on this edge
            sample_valid <= sck_rise & (bit_cnt == 6'd24);
        end
    end

    //------------------------------
    // Data capture

    always_ff @ (posedge clk)
    begin
        if (sck_rise & in_slot)
            shift <= { shift [w_mic_bits - 2:0], sd };
    end

    // Shift register holds the word until the next left slot starts
    assign sample = shift;

    assign mic = '{ sck: sck, ws: bit_cnt [5], lr: 1'b0 };

endmodule

/* verilog/sample_fifo.sv */
`timescale 1ns/100ps

module sample_fifo
# (
    parameter fifo_depth_log = 3
)
(
    input                          clk,
    input                          rst,
    input                          push,
    input  audio_pkg::mic_sample_t data,
    input                          pop,
    output audio_pkg::mic_sample_t head,
    output logic                   not_empty,
    output logic                   overflow
);

    import audio_pkg::*;

    localparam depth = 2 ** fifo_depth_log;

    mic_sample_t                mem [0:depth - 1];
    logic [fifo_depth_log - 1:0] wr_ptr;
    logic [fifo_depth_log - 1:0] rd_ptr;
    logic [fifo_depth_log    :0] count;

    wire full    = (count == (fifo_depth_log + 1)' (depth));
    wire do_pop  = pop & not_empty;
    wire do_push = push & (~ full | do_pop);   // A pop frees the slot in the same cycle

    //------------------------------
    // Pointers and flags

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;

            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({ do_push, do_pop })
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (push & ~ do_push)
                overflow <= 1'b1;   // Sample dropped
        end
    end

    //------------------------------
    // Storage

    always_ff @ (posedge clk)
    begin
        if (do_push)
            mem [wr_ptr] <= data;
    end

    assign head      = mem [rd_ptr];   // First word falls through
    assign not_empty = (count != '0);

endmodule

/* verilog/i2s_audio_out.sv */
`timescale 1ns/100ps

module i2s_audio_out
# (
    parameter out_half_period = 5
)
(
    input                            clk,
    input                            rst,
    input                            mute,
    input  audio_pkg::mic_sample_t   head,
    input                            not_empty,
    output logic                     pop,
    output audio_pkg::i2s_out_pins_t pins,
    output logic                     underrun
);

    import audio_pkg::*;

    localparam w_div = $clog2 (out_half_period + 1);

    logic [w_div - 1:0] div_cnt;
    logic               mclk;
    logic               bclk;
    logic [        4:0] bit_cnt;      // bclk cycle within the 32-cycle frame
    logic               first_frame;
    logic               sdata;
    sound_t             held;         // Last sample taken from the FIFO
    sound_t             tx_word;      // Word sent in both slots of this frame
    sound_t             shift;
    sound_t             word_next;
    sound_t             tx_word_next;

    //------------------------------
    // Clock generation

    wire toggle     = (div_cnt == w_div' (out_half_period - 1));
    wire bclk_fall  = toggle & bclk;
    wire slot_start = bclk_fall & (bit_cnt [3:0] == 4'hf);   // lrclk changes here

    // Reset leaves lrclk low, so the cycle after it opens a frame too
    wire frame_start = (bclk_fall & (bit_cnt == 5'd31)) | first_frame;

    assign pop          = frame_start & not_empty;
    assign word_next    = not_empty ? head [w_mic_bits - 1 -: w_sound_bits] : held;
    assign tx_word_next = mute ? '0 : word_next;

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            div_cnt     <= '0;
            mclk        <= 1'b0;
            bclk        <= 1'b0;
            bit_cnt     <= '0;
            first_frame <= 1'b1;
            underrun    <= 1'b0;
            held        <= '0;
        end
        else
        begin
            mclk        <= ~ mclk;
            first_frame <= 1'b0;

            if (toggle)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (toggle)
                bclk <= ~ bclk;

            if (bclk_fall)
                bit_cnt <= bit_cnt + 1'b1;

            if (frame_start)
            begin
                held <= word_next;           // Repeats on an empty FIFO
                if (~ not_empty)
                    underrun <= 1'b1;
            end
        end
    end

    //------------------------------
    // Serializer

    always_ff @ (posedge clk)
    begin
        if (frame_start)
            tx_word <= tx_word_next;
    end

    // Previous LSB leaves on the slot edge, so the MSB follows one bclk later
    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            shift <= '0;
            sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            sdata <= shift [w_sound_bits - 1];

            if (slot_start)
                shift <= frame_start ? tx_word_next : tx_word;
            else
                shift <= shift << 1;
        end
    end

    assign pins = '{ mclk: mclk, bclk: bclk, lrclk: bit_cnt [4], sdata: sdata };

endmodule

/* verilog/audio_board_top.sv */
`timescale 1ns/100ps

`include "board_config.svh"

module audio_board_top
# (
    parameter clk_mhz         = `CLK_MHZ,          // Board clock
              mic_half_period = `MIC_HALF_PERIOD,
              out_half_period = `OUT_HALF_PERIOD,
              fifo_depth_log  = 3
)
(
    input                            clk,
    input                            rst,
    input                            mute,
    input                            mic_sd,
    output audio_pkg::mic_pins_t     mic,
    output audio_pkg::i2s_out_pins_t audio,
    output audio_pkg::audio_flags_t  led
);

    import audio_pkg::*;

    mic_sample_t sample;
    logic        sample_valid;
    mic_sample_t head;
    logic        not_empty;
    logic        pop;
    logic        overflow;
    logic        underrun;

    //------------------------------
    // Producer

    inmp441_mic_i2s_receiver
    # (
        .mic_half_period ( mic_half_period )
    )
    i_mic
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sd           ( mic_sd       ),
        .mic          ( mic          ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    //------------------------------
    // Buffer

    sample_fifo
    # (
        .fifo_depth_log ( fifo_depth_log )
    )
    i_fifo
    (
        .clk       ( clk          ),
        .rst       ( rst          ),
        .push      ( sample_valid ),   // No ready, full drops
        .data      ( sample       ),
        .pop       ( pop          ),
        .head      ( head         ),
        .not_empty ( not_empty    ),
        .overflow  ( overflow     )
    );

    //------------------------------
    // Consumer

    i2s_audio_out
    # (
        .out_half_period ( out_half_period )
    )
    i_audio_out
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .mute      ( mute      ),
        .head      ( head      ),
        .not_empty ( not_empty ),
        .pop       ( pop       ),
        .pins      ( audio     ),
        .underrun  ( underrun  )
    );

    assign led = '{ overflow: overflow, underrun: underrun };

endmodule

/* verif/tb_mic_model.sv */
`timescale 1ns/100ps

module tb_mic_model
(
    input                          rst,
    input  audio_pkg::mic_pins_t   mic,
    output                         sd,
    output audio_pkg::mic_sample_t sent,
    output                         sent_valid
);

    import audio_pkg::*;

    integer      seed    = 32'h7bbd;
    int          slot    = 0;       // sck cycle since ws fell
    logic        ws_prev = 1'b0;
    mic_sample_t word    = '0;
    mic_sample_t tx_bits = '0;
    logic        sd_r    = 1'b0;
    mic_sample_t sent_r  = '0;
    logic        valid_r = 1'b0;

    //------------------------------
    // Serial answer to sck and ws

    // ws settles in the same step as the sck fall
    always @ (negedge mic.sck)
    begin
        #1;

        if (rst)
            slot = 0;
        else if (ws_prev & ~ mic.ws)
            slot = 0;                  // Left slot opens
        else
            slot = slot + 1;

        ws_prev = mic.ws;

        if (slot == 1)
        begin
            word    = mic_sample_t' ($random (seed));
            tx_bits = word;
            sent_r  = word;            // Held until the next slot opens
        end

        // One-bit delay after ws, then MSB first
        if (slot >= 1 && slot <= w_mic_bits)
        begin
            sd_r    = tx_bits [w_mic_bits - 1];
            tx_bits = tx_bits << 1;
        end
        else
            sd_r = 1'b0;

        valid_r = (slot == w_mic_bits);   // LSB now on the wire
    end

    assign sd         = sd_r;
    assign sent       = sent_r;
    assign sent_valid = valid_r;

endmodule

/* verif/tb_audio_board_top.sv */
`timescale 1ns/100ps

`include "board_config.svh"

module tb_audio_board_top;

    import audio_pkg::*;

    localparam real clk_period     = 1000.0 / `CLK_MHZ;
    localparam int  mic_frame_clks = 128 * `MIC_HALF_PERIOD;
    localparam int  out_frame_clks = 64 * `OUT_HALF_PERIOD;
    localparam int  n_loop_frames  = 10;
    localparam int  n_mute_frames  = 4;
    localparam int  n_after_mute   = 6;
    localparam int  ovf_limit_clks = 60 * mic_frame_clks;
    localparam int  n_after_ovf    = 8;
    localparam int  total_frames   = 2 + n_loop_frames + n_mute_frames + n_after_mute + 2
                                     + ovf_limit_clks / out_frame_clks + 1 + n_after_ovf;

    logic          clk  = 1'b0;
    logic          rst  = 1'b1;
    logic          mute = 1'b0;
    logic          mic_sd;
    mic_pins_t     mic;
    i2s_out_pins_t audio;
    audio_flags_t  led;
    mic_sample_t   sent;
    logic          sent_valid;

    mic_sample_t   exp_q [$];           // Samples sent by the microphone model
    sound_t        rx_left  [0:255];
    sound_t        rx_right [0:255];
    logic          rx_mute  [0:255];
    int            frames_rx    = 0;
    int            next_frame   = 0;
    int            cycles       = 0;
    int            test_errors  = 0;
    int            tests_passed = 0;
    int            tests_failed = 0;
    int            queue_words  = 0;    // Unmuted words matched to the queue
    sound_t        last_word    = '0;
    logic          last_lrclk   = 1'b0;
    logic          frame_mute   = 1'b0;
    logic          left_mute    = 1'b0;
    sound_t        rx_shift     = '0;
    sound_t        left_word    = '0;
    logic          mclk_exp;
    int            muted_seen;
    logic          ovf_seen;

    audio_board_top
    # (
        .clk_mhz         ( `CLK_MHZ         ),
        .mic_half_period ( `MIC_HALF_PERIOD ),
        .out_half_period ( `OUT_HALF_PERIOD )
    )
    i_dut
    (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .mute   ( mute   ),
        .mic_sd ( mic_sd ),
        .mic    ( mic    ),
        .audio  ( audio  ),
        .led    ( led    )
    );

    tb_mic_model i_mic_model
    (
        .rst        ( rst        ),
        .mic        ( mic        ),
        .sd         ( mic_sd     ),
        .sent       ( sent       ),
        .sent_valid ( sent_valid )
    );

    always #(clk_period / 2) clk = ~ clk;

    always @ (posedge clk)
        if (rst)
            cycles <= 0;
        else
            cycles <= cycles + 1;

    always @ (posedge sent_valid)
        exp_q.push_back (sent);

    //------------------------------
    // I2S output decoder

    always @ (negedge audio.lrclk)
        frame_mute = mute;             // Level the DUT took at frame start

    // A slot is complete one bclk after the next lrclk change
    always @ (posedge audio.bclk)
    begin
        rx_shift = { rx_shift [w_sound_bits - 2:0], audio.sdata };

        if (audio.lrclk != last_lrclk)
        begin
            if (last_lrclk == 1'b0)
            begin
                left_word = rx_shift;
                left_mute = frame_mute;
            end
            else
            begin
                rx_left  [8' (frames_rx)] = left_word;
                rx_right [8' (frames_rx)] = rx_shift;
                rx_mute  [8' (frames_rx)] = left_mute;
                frames_rx++;
            end
            last_lrclk = audio.lrclk;
        end
    end

    //------------------------------
    // Reference and checks

    function automatic sound_t expected_sound (input mic_sample_t s, input logic muted);
        if (muted)
            return '0;
        return s [w_mic_bits - 1 -: w_sound_bits];
    endfunction

    task automatic check_value (input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
        assert (actual === expected)
        else
        begin
            $display ("ERR %s: expected %h, got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_reset_state (input string when);
        check_value ({ "led ",          when }, 16' (led),         16'h0);
        check_value ({ "mic.sck ",      when }, 16' (mic.sck),     16'h0);
        check_value ({ "mic.ws ",       when }, 16' (mic.ws),      16'h0);
        check_value ({ "mic.lr ",       when }, 16' (mic.lr),      16'h0);
        check_value ({ "audio.bclk ",   when }, 16' (audio.bclk),  16'h0);
        check_value ({ "audio.lrclk ",  when }, 16' (audio.lrclk), 16'h0);
        check_value ({ "audio.sdata ",  when }, 16' (audio.sdata), 16'h0);
    endtask

    task automatic wait_frame (input int k);
        wait (frames_rx > k);
    endtask

    task automatic check_frame (input int k);
        sound_t left;
        sound_t right;
        logic   muted;
        logic   repeat_ok;
        int     hit;
        int     i;

        left  = rx_left  [8' (k)];
        right = rx_right [8' (k)];
        muted = rx_mute  [8' (k)];
        check_value ("audio.sdata right word", right, left);
        if (muted)
            check_value ("audio.sdata muted word", left, 16'h0);

        hit = -1;
        if (led.overflow)
        begin
            // Dropped pushes leave gaps, order still holds
            for (i = 0; i < exp_q.size () && hit < 0; i++)
                if (expected_sound (exp_q [i], muted) == left)
                    hit = i;
        end
        else if (exp_q.size () != 0 && expected_sound (exp_q [0], muted) == left)
            hit = 0;

        repeat_ok = ~ led.overflow & led.underrun & (left == last_word) & ~ muted;

        assert (hit >= 0 || repeat_ok)
        else
        begin
            if (exp_q.size () == 0)
                $display ("Output frame %0d arrived with no microphone sample left", k);
            else
                $display ("ERR audio.sdata left word: expected %h, got %h",
                          expected_sound (exp_q [0], muted), left);
            test_errors++;
        end

        if (hit >= 0 && !muted)
            queue_words++;

        if (hit >= 0)
            repeat (hit + 1)
                exp_q.delete (0);
        last_word = left;
    endtask

    task automatic finish_test (input string name);
        if (test_errors == 0)
        begin
            $display ("test %s: ok", name);
            tests_passed++;
        end
        else
        begin
            $display ("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    //------------------------------
    // Test sequence

    initial
    begin
        repeat (3) @ (posedge clk);
        #1;
        check_reset_state ("during reset");
        repeat (5) @ (posedge clk);
        #1 rst = 1'b0;
        #1;
        check_reset_state ("after reset");

        // Master clock toggles on every clk
        repeat (4)
        begin
            mclk_exp = ~ audio.mclk;
            @ (posedge clk);
            #1;
            check_value ("audio.mclk", 16' (audio.mclk), 16' (mclk_exp));
        end
        finish_test ("reset state");

        // First frame starts before any sample is buffered
        wait_frame (0);
        check_value ("audio.sdata left word",  rx_left  [0], 16'h0);
        check_value ("audio.sdata right word", rx_right [0], 16'h0);
        check_value ("led.underrun", 16' (led.underrun), 16'h1);
        next_frame = 1;
        finish_test ("startup underrun");

        queue_words = 0;
        repeat (n_loop_frames)
        begin
            wait_frame (next_frame);
            check_frame (next_frame);
            next_frame++;
        end
        assert (queue_words > 0)
        else
        begin
            $display ("No output word was taken from the microphone samples");
            test_errors++;
        end
        finish_test ("in-order loopback");

        @ (posedge clk);
        #1 mute = 1'b1;
        muted_seen = 0;
        while (muted_seen < n_mute_frames)
        begin
            wait_frame (next_frame);
            check_frame (next_frame);
            if (rx_mute [8' (next_frame)])
                muted_seen++;
            next_frame++;
        end
        @ (posedge clk);
        #1 mute = 1'b0;
        queue_words = 0;
        repeat (n_after_mute)
        begin
            wait_frame (next_frame);
            check_frame (next_frame);
            next_frame++;
        end
        assert (queue_words > 0)
        else
        begin
            $display ("Output stayed muted after mute was released");
            test_errors++;
        end
        finish_test ("mute");

        // Consumer frames are longer, so the FIFO fills up
        ovf_seen = 1'b0;
        while (!ovf_seen && cycles < ovf_limit_clks)
        begin
            wait_frame (next_frame);
            check_frame (next_frame);
            next_frame++;
            ovf_seen = led.overflow;
        end
        assert (ovf_seen)
        else
        begin
            $display ("led.overflow did not rise within 60 microphone frames");
            test_errors++;
        end
        if (ovf_seen)
            repeat (n_after_ovf)
            begin
                wait_frame (next_frame);
                check_frame (next_frame);
                check_value ("led.overflow", 16' (led.overflow), 16'h1);
                next_frame++;
            end
        finish_test ("overflow");

        $display ("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display ("*** PASSED ***");
        else
            $display ("*** FAILED ***");
        $finish;
    end

    // Run limit from the frame count of all tests
    initial
    begin
        #(1.5 * total_frames * out_frame_clks * clk_period);
        $display ("Timeout: tests did not finish, %0d output frames decoded", frames_rx);
        $display ("*** FAILED ***");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
verilog/audio_pkg.sv
verilog/inmp441_mic_i2s_receiver.sv
verilog/sample_fifo.sv
verilog/i2s_audio_out.sv
verilog/audio_board_top.sv
verif/tb_mic_model.sv
verif/tb_audio_board_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_audio_board_top
FILELIST = sources.f
OBJ_DIR  = obj_dir
PASS_MSG = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
